/* hdl/tile_engine_macros.svh */
/* Widths, counts and tile-entry field positions for the tile engine.
 * Included by the packages and by every RTL module that sizes a port or a buffer.
 */
`ifndef TILE_ENGINE_MACROS_SVH
`define TILE_ENGINE_MACROS_SVH

// Word and address widths
`define TILE_ENTRY_W     16
`define MEM_WORD_W       64
`define TILRAM_ADDR_W    11
`define PATRAM_ADDR_W    12
`define PIXEL_ADDR_W     9
`define SLOT_W           6      // Slot index into the row buffers

// Counts per prepared row
`define TILE_CHUNKS      11     // Tile RAM reads, four entries each
`define TILE_SLOTS       44
`define TILE_BUF_DEPTH   16     // Tile-entry buffer words
`define ROW_BUF_DEPTH    64     // Pattern store slots

// Tile entry fields
`define PAT_BASE_MSB     15
`define PAT_BASE_LSB     6
`define PALETTE_MSB      5
`define PALETTE_LSB      2
`define YMIR_BIT         1
`define XMIR_BIT         0
`endif

/* hdl/tile_mem_pkg.sv */
/* Word layouts of the two external memories seen by the tile engine.
 * Tile RAM words hold four tile entries, Pattern RAM words hold two pixel rows.
 */
`default_nettype none

`include "tile_engine_macros.svh"

package tile_mem_pkg;

    // ================================================
    // Tile RAM word
    // ================================================
    // Entry k of a word read for chunk c is tile 4*c+k
    typedef union packed {
        logic [`MEM_WORD_W-1:0]                 raw;
        logic [3:0][`TILE_ENTRY_W-1:0]          entry;    // entry[0] in bits 15:0
    } tile_ram_word_u;

    // ================================================
    // Pattern RAM word
    // ================================================
    // rows[0] is the even pixel row (low half), rows[1] the odd one
    // Pixel p of a row sits in nibble p, so pixel 0 is leftmost on screen
    typedef union packed {
        logic [`MEM_WORD_W-1:0]                 raw;
        logic [1:0][7:0][3:0]                   rows;
    } pattern_word_u;

endpackage : tile_mem_pkg

`default_nettype wire

/* hdl/tile_geom_pkg.sv */
/* Screen geometry words of the tile engine.
 * Covers the CPU scroll register and the pixel word returned to the mixer.
 */
`default_nettype none

package tile_geom_pkg;

    // Scroll register, both offsets in world pixels modulo 512
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [6:0] rsvd_hi;      // Bits 31:25, ignored
            logic [8:0] scroll_y;     // Bits 24:16
            logic [6:0] rsvd_lo;      // Bits 15:9, ignored
            logic [8:0] scroll_x;     // Bits 8:0
        } fld;
    } scroll_reg_u;

    // Pixel word to the mixer
    // Palette picks one of 16 palettes, colour the entry within it
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [3:0] palette;
            logic [3:0] colour;       // 0 is transparent
        } fld;
    } pixel_out_u;

endpackage : tile_geom_pkg

`default_nettype wire

/* hdl/row_geometry_if.sv */
/* Per-row scroll geometry, driven by the top level and read by the fetchers
 * and the pixel row buffer. Values are combinational from scroll and next_row.
 */
`timescale 1ns/100ps
`default_nettype none

interface row_geometry_if;

    logic [5:0] tilerow;          // Pixel row bits 8:3, tile row in Tile RAM
    logic [1:0] pair_sel;         // Pixel row bits 2:1, row pair in a pattern
    logic       row_lsb;          // Pixel row bit 0, even or odd row of the pair
    logic [5:0] tile_scroll_x;    // First visible tile column
    logic [2:0] pixel_scroll_x;   // Pixel offset inside that tile

    modport src  (output tilerow, pair_sel, row_lsb, tile_scroll_x, pixel_scroll_x);

    modport sink (input  tilerow, pair_sel, row_lsb, tile_scroll_x, pixel_scroll_x);

endinterface : row_geometry_if

`default_nettype wire

/* hdl/tilram_fetcher.sv */
/* Copies the tile entries of one tile row from Tile RAM into a local buffer.
 * Started by fetch_start, pulses tiles_done after the last write. The buffer
 * read port serves the pattern fetcher during prepare and the mixer otherwise.
 */
`timescale 1ns/100ps
`default_nettype none

`include "tile_engine_macros.svh"

module tilram_fetcher import tile_mem_pkg::*; #(
    parameter logic fg_select = 1'b0                  // Tile RAM half, 1 is FG
) (
    input  logic                        clk,
    input  logic                        rst_n,
    row_geometry_if.sink                geom,
    input  logic                        fetch_start,
    output logic [`TILRAM_ADDR_W-1:0]   tilram_addr,
    input  tile_ram_word_u              tilram_rddata,
    input  logic                        prep_active,
    input  logic [`SLOT_W-1:0]          slot_fetch,
    input  logic [`SLOT_W-1:0]          slot_pixel,
    output logic [`TILE_ENTRY_W-1:0]    entry,
    output logic                        tiles_done
);

    logic                busy;          // Addresses going out
    logic [3:0]          chunk_cnt;     // Chunks issued so far
    logic [3:0]          chunk;         // Scrolled chunk in the 16-chunk row
    logic                wr_en;
    logic [3:0]          wr_idx;
    logic [`SLOT_W-1:0]  rd_slot;

    tile_ram_word_u tile_buf [`TILE_BUF_DEPTH];   // Only 11 words used per row

    // ================================================
    // Tile RAM address
    // ================================================
    assign chunk       = geom.tile_scroll_x[5:2] + chunk_cnt;   // Wraps inside the row
    assign tilram_addr = {fg_select, geom.tilerow, chunk};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            chunk_cnt  <= '0;
            wr_en      <= 1'b0;
            tiles_done <= 1'b0;
        end else begin
            wr_en      <= busy;                                     // Data one cycle behind
            tiles_done <= wr_en && (wr_idx == 4'(`TILE_CHUNKS - 1));
            if (fetch_start) begin
                busy      <= 1'b1;
                chunk_cnt <= '0;
            end else if (busy) begin
                chunk_cnt <= chunk_cnt + 4'd1;
                if (chunk_cnt == 4'(`TILE_CHUNKS - 1))
                    busy <= 1'b0;                                   // Last address out
            end
        end
    end

    // ================================================
    // Buffer write and read ports
    // ================================================
    // Buffer word 0 is the first scrolled chunk, so slot s is tile 4*chunk0+s
    assign rd_slot = prep_active ? slot_fetch : slot_pixel;

    always_ff @(posedge clk) begin
        wr_idx <= chunk_cnt;
        if (wr_en)
            tile_buf[wr_idx].raw <= tilram_rddata.raw;
        entry <= tile_buf[rd_slot[5:2]].entry[rd_slot[1:0]];        // One cycle latency
    end

endmodule : tilram_fetcher

`default_nettype wire

/* hdl/patram_fetcher.sv */
/* Walks the 44 buffered tile slots and fetches two pattern rows for each one.
 * Three-stage pipeline: entry read, Pattern RAM address, mirrored write to the
 * pixel row buffer. Pulses patterns_done after the last write.
 */
`timescale 1ns/100ps
`default_nettype none

`include "tile_engine_macros.svh"

module patram_fetcher import tile_mem_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    row_geometry_if.sink                geom,
    input  logic                        tiles_done,
    input  logic [`TILE_ENTRY_W-1:0]    entry,
    output logic [`SLOT_W-1:0]          slot_fetch,
    output logic [`PATRAM_ADDR_W-1:0]   patram_addr,
    input  pattern_word_u               patram_rddata,
    output logic [`SLOT_W-1:0]          wr_slot,
    output pattern_word_u               wr_word,
    output logic                        wr_en,
    output logic                        patterns_done
);

    logic                busy;        // Stage 1 valid
    logic [`SLOT_W-1:0]  slot_cnt;
    logic                s2_valid;
    logic [`SLOT_W-1:0]  s2_slot;
    logic [1:0]          pair;        // Row pair after y-mirror
    logic                x_mir;       // Mirror bits of the stage 3 slot
    logic                y_mir;

    // Swap rows for y-mirror, reverse pixels within each row for x-mirror
    function automatic pattern_word_u mirror_word(pattern_word_u w, logic xm, logic ym);
        pattern_word_u m;
        for (int r = 0; r < 2; r++) begin
            for (int p = 0; p < 8; p++) begin
                m.rows[r ^ int'(ym)][p ^ int'({3{xm}})] = w.rows[r][p];
            end
        end
        return m;
    endfunction

    // ================================================
    // Stage 1, entry read
    // ================================================
    assign slot_fetch = slot_cnt;

    // ================================================
    // Stage 2, Pattern RAM address
    // ================================================
    // A y-mirrored tile shows row 7-r, which lives in the opposite pair
    assign pair        = entry[`YMIR_BIT] ? ~geom.pair_sel : geom.pair_sel;
    assign patram_addr = {entry[`PAT_BASE_MSB:`PAT_BASE_LSB], pair};

    // ================================================
    // Stage 3, mirrored write
    // ================================================
    assign wr_word = mirror_word(patram_rddata, x_mir, y_mir);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy          <= 1'b0;
            slot_cnt      <= '0;
            s2_valid      <= 1'b0;
            wr_en         <= 1'b0;
            patterns_done <= 1'b0;
        end else begin
            s2_valid      <= busy;
            wr_en         <= s2_valid;
            patterns_done <= wr_en && (wr_slot == `SLOT_W'(`TILE_SLOTS - 1));
            if (tiles_done) begin
                busy     <= 1'b1;
                slot_cnt <= '0;
            end else if (busy) begin
                slot_cnt <= slot_cnt + 1'b1;
                if (slot_cnt == `SLOT_W'(`TILE_SLOTS - 1))
                    busy <= 1'b0;
            end
        end
    end

    // Slot number and mirror bits ride along with the data
    always_ff @(posedge clk) begin
        s2_slot <= slot_cnt;
        wr_slot <= s2_slot;
        x_mir   <= entry[`XMIR_BIT];
        y_mir   <= entry[`YMIR_BIT];
    end

endmodule : patram_fetcher

`default_nettype wire

/* hdl/pixel_row_buffer.sv */
/* Pattern store for the prepared row and the mixer read path.
 * Maps a mixer pixel address through the x scroll to a slot and a pixel,
 * returns palette and colour one cycle later, forced to zero when disabled.
 */
`timescale 1ns/100ps
`default_nettype none

`include "tile_engine_macros.svh"

module pixel_row_buffer import tile_mem_pkg::*, tile_geom_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    row_geometry_if.sink                geom,
    input  logic                        enable,
    input  logic [`PIXEL_ADDR_W-1:0]    pixel_addr,
    input  logic [`SLOT_W-1:0]          wr_slot,
    input  pattern_word_u               wr_word,
    input  logic                        wr_en,
    output logic [`SLOT_W-1:0]          slot_pixel,
    input  logic [`TILE_ENTRY_W-1:0]    entry,
    output pixel_out_u                  pixel_data
);

    logic [`PIXEL_ADDR_W-1:0] scrolled;     // Pixel offset from the first fetched tile
    logic [2:0]               pix_idx;
    logic [3:0]               colour_q;

    pattern_word_u pat_buf [`ROW_BUF_DEPTH];

    // Slot 0 holds the tile at the start of the scrolled chunk
    assign scrolled   = pixel_addr + geom.pixel_scroll_x;
    assign slot_pixel = geom.tile_scroll_x[1:0] + scrolled[8:3];   // Same slot for palette
    assign pix_idx    = scrolled[2:0];

    always_ff @(posedge clk) begin
        if (wr_en)
            pat_buf[wr_slot].raw <= wr_word.raw;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            colour_q <= '0;
        else
            colour_q <= pat_buf[slot_pixel].rows[geom.row_lsb][pix_idx];
    end

    // Entry arrives from the tile buffer with the same one-cycle latency
    always_comb begin
        pixel_data.raw = '0;                // Transparent while disabled
        if (enable) begin
            pixel_data.fld.palette = entry[`PALETTE_MSB:`PALETTE_LSB];
            pixel_data.fld.colour  = colour_q;
        end
    end

endmodule : pixel_row_buffer

`default_nettype wire

/* hdl/tile_engine.sv */
/* Tile engine for one background or foreground layer.
 * A prep pulse fills the row buffers for next_row, done pulses when they are
 * full, and the mixer then reads pixels by address with one cycle latency.
 */
`timescale 1ns/100ps
`default_nettype none

`include "tile_engine_macros.svh"

module tile_engine import tile_mem_pkg::*, tile_geom_pkg::*; #(
    parameter logic fg_select = 1'b0                      // Tile RAM half, 1 is FG
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [7:0]                  next_row,         // Scan line to prepare
    output logic [`TILRAM_ADDR_W-1:0]   tilram_addr,
    input  tile_ram_word_u              tilram_rddata,
    output logic [`PATRAM_ADDR_W-1:0]   patram_addr,
    input  pattern_word_u               patram_rddata,
    input  scroll_reg_u                 scroll,
    input  logic                        enable,
    input  logic                        prep,
    input  logic [`PIXEL_ADDR_W-1:0]    pixel_addr,
    output pixel_out_u                  pixel_data,
    output logic                        done
);

    localparam logic IDLE = 1'b0;
    localparam logic PREP = 1'b1;

    logic                       state;
    logic                       prep_active;
    logic                       fetch_start;
    logic                       done_pending;
    logic                       tiles_done;
    logic                       patterns_done;
    logic [`PIXEL_ADDR_W-1:0]   pixel_row;        // World pixel row, wraps at 512
    logic [`SLOT_W-1:0]         slot_fetch;
    logic [`SLOT_W-1:0]         slot_pixel;
    logic [`TILE_ENTRY_W-1:0]   entry;
    logic [`SLOT_W-1:0]         wr_slot;
    pattern_word_u              wr_word;
    logic                       wr_en;

    row_geometry_if geom ();

    // ================================================
    // Row geometry
    // ================================================
    assign pixel_row           = scroll.fld.scroll_y + next_row;
    assign geom.tilerow        = pixel_row[8:3];
    assign geom.pair_sel       = pixel_row[2:1];
    assign geom.row_lsb        = pixel_row[0];
    assign geom.tile_scroll_x  = scroll.fld.scroll_x[8:3];
    assign geom.pixel_scroll_x = scroll.fld.scroll_x[2:0];

    // ================================================
    // Prepare FSM
    // ================================================
    assign prep_active = (state == PREP);   // Tile buffer port to the pattern fetcher

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            fetch_start  <= 1'b0;
            done_pending <= 1'b0;
            done         <= 1'b0;
        end else begin
            fetch_start  <= (state == IDLE) && prep;
            done_pending <= (state == PREP) && patterns_done;
            done         <= done_pending;   // Pulse lands one cycle into IDLE
            if (state == IDLE && prep)
                state <= PREP;
            else if (state == PREP && patterns_done)
                state <= IDLE;              // Prep ignored until here
        end
    end

    tilram_fetcher #(.fg_select(fg_select)) u_tilram_fetcher (
        .clk, .rst_n, .geom(geom.sink), .fetch_start, .tilram_addr, .tilram_rddata,
        .prep_active, .slot_fetch, .slot_pixel, .entry, .tiles_done
    );

    patram_fetcher u_patram_fetcher (
        .clk, .rst_n, .geom(geom.sink), .tiles_done, .entry, .slot_fetch, .patram_addr,
        .patram_rddata, .wr_slot, .wr_word, .wr_en, .patterns_done
    );

    pixel_row_buffer u_pixel_row_buffer (
        .clk, .rst_n, .geom(geom.sink), .enable, .pixel_addr, .wr_slot, .wr_word, .wr_en,
        .slot_pixel, .entry, .pixel_data
    );

endmodule : tile_engine

`default_nettype wire

/* verification/tb_clock_gen.sv */
/* Clock and reset source for the tile engine testbench.
 * Free-running clk, rst_n held low for a fixed number of cycles.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;        // 50 % duty cycle
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);                             // Release away from the active edge
        rst_n = 1'b1;
    end

endmodule : tb_clock_gen

`default_nettype wire

/* verification/tile_engine_properties.sv */
/* Port-level assertions for tile_engine, bound into every instance.
 * Counts its own failures so the testbench can see them.
 */
`timescale 1ns/100ps
`default_nettype none

`include "tile_engine_macros.svh"

module tile_engine_properties import tile_geom_pkg::*; #(
    parameter logic fg_select = 1'b0
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        done,
    input  logic                        enable,
    input  pixel_out_u                  pixel_data,
    input  logic [`TILRAM_ADDR_W-1:0]   tilram_addr
);

    int assert_errors = 0;      // Read by the testbench monitor

    // done is a single-cycle pulse
    done_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else begin
            assert_errors++;
            $error("done high for two cycles in a row");
        end

    // Disabled layer is fully transparent
    pixel_zero_when_disabled: assert property (@(posedge clk) disable iff (!rst_n)
        !enable |-> (pixel_data.raw == 8'h00))
        else begin
            assert_errors++;
            $error("pixel_data not zero while enable is low");
        end

    // Layer only ever reads its own Tile RAM half
    tilram_half_matches: assert property (@(posedge clk) disable iff (!rst_n)
        tilram_addr[`TILRAM_ADDR_W-1] == fg_select)
        else begin
            assert_errors++;
            $error("tilram_addr outside the selected Tile RAM half");
        end

endmodule : tile_engine_properties

`default_nettype wire

/* verification/tb_tile_engine.sv */
/* Self-checking testbench for tile_engine with the FG half selected.
 * Loads both RAM images and the pixel cases from the input file, prepares
 * each new row once and checks every mixer read against its expected word.
 */
`timescale 1ns/100ps
`default_nettype none

`include "tile_engine_macros.svh"

module tb_tile_engine import tile_mem_pkg::*, tile_geom_pkg::*; ();

    localparam int max_cases     = 64;
    localparam int prep_timeout  = 300;     // Cycles from prep to done
    localparam int reset_timeout = 20;

    logic                        clk;
    logic                        rst_n;
    logic [7:0]                  next_row;
    scroll_reg_u                 scroll;
    logic                        enable;
    logic                        prep;
    logic [`TILRAM_ADDR_W-1:0]   tilram_addr;
    tile_ram_word_u              tilram_rddata;
    logic [`PATRAM_ADDR_W-1:0]   patram_addr;
    pattern_word_u               patram_rddata;
    logic [`PIXEL_ADDR_W-1:0]    pixel_addr;
    pixel_out_u                  pixel_data;
    logic                        done;

    logic [`MEM_WORD_W-1:0] tile_mem [1 << `TILRAM_ADDR_W];
    logic [`MEM_WORD_W-1:0] pat_mem  [1 << `PATRAM_ADDR_W];

    // Case table, one entry per C record
    scroll_reg_u              case_scroll [max_cases];
    logic [7:0]               case_row    [max_cases];
    logic                     case_enable [max_cases];
    logic [`PIXEL_ADDR_W-1:0] case_addr   [max_cases];
    pixel_out_u               case_expect [max_cases];
    int                       num_cases;

    tb_clock_gen #(.period_ns(40), .reset_cycles(4)) u_clock_gen (.clk, .rst_n);

    tile_engine #(.fg_select(1'b1)) uut (
        .clk, .rst_n, .next_row, .tilram_addr, .tilram_rddata, .patram_addr, .patram_rddata,
        .scroll, .enable, .prep, .pixel_addr, .pixel_data, .done
    );

    bind tile_engine tile_engine_properties #(.fg_select(fg_select)) u_props (
        .clk(clk), .rst_n(rst_n), .done(done), .enable(enable), .pixel_data(pixel_data),
        .tilram_addr(tilram_addr)
    );

    // ==================================================
    // External RAM models
    // ==================================================
    always @(posedge clk) begin
        tilram_rddata.raw <= tile_mem[tilram_addr];     // One cycle read latency
        patram_rddata.raw <= pat_mem[patram_addr];
    end

    always @(negedge clk) begin
        if (uut.u_props.assert_errors != 0) begin
            $display("Assertion failure reported by tile_engine_properties");
            abort_run();
        end
    end

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at first failure");
    endtask

    task automatic check_pixel(input pixel_out_u actual, input pixel_out_u expected,
                               input int idx);
        if (actual.raw !== expected.raw) begin
            $display("ERROR: pixel_data = 0x%h, expected 0x%h (case %0d, pixel_addr 0x%h)",
                     actual.raw, expected.raw, idx, pixel_addr);
            abort_run();
        end
    endtask

    task automatic check_done(input logic expected, input string phase);
        if (done !== expected) begin
            $display("ERROR: done = 0x%h, expected 0x%h (%s)", done, expected, phase);
            abort_run();
        end
    endtask

    // ==================================================
    // Input file
    // ==================================================
    task automatic load_input_file();
        int               fd;
        int               code;
        logic [7:0]       kind;
        logic [31:0]      rec_addr;
        logic [63:0]      rec_word;
        logic [31:0]      rec_scroll;
        logic [31:0]      rec_row;
        logic [31:0]      rec_enable;
        logic [31:0]      rec_pixel;
        logic [31:0]      rec_expect;
        logic [8*160-1:0] rest;
        for (int a = 0; a < (1 << `TILRAM_ADDR_W); a++)
            tile_mem[a] = '0;
        for (int a = 0; a < (1 << `PATRAM_ADDR_W); a++)
            pat_mem[a] = '0;
        fd = $fopen("verification/tile_engine_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the input file verification/tile_engine_input.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1)
                break;
            if (kind == "#") begin
                code = $fgets(rest, fd);                    // Comment line
            end else if (kind == "T") begin
                code = $fscanf(fd, "%h %h", rec_addr, rec_word);
                tile_mem[rec_addr[`TILRAM_ADDR_W-1:0]] = rec_word;
            end else if (kind == "P") begin
                code = $fscanf(fd, "%h %h", rec_addr, rec_word);
                pat_mem[rec_addr[`PATRAM_ADDR_W-1:0]] = rec_word;
            end else if (kind == "C" && num_cases < max_cases) begin
                code = $fscanf(fd, "%h %h %h %h %h", rec_scroll, rec_row, rec_enable,
                               rec_pixel, rec_expect);
                case_scroll[num_cases].raw = rec_scroll;
                case_row[num_cases]        = rec_row[7:0];
                case_enable[num_cases]     = rec_enable[0];
                case_addr[num_cases]       = rec_pixel[`PIXEL_ADDR_W-1:0];
                case_expect[num_cases].raw = rec_expect[7:0];
                num_cases++;
            end else begin
                $display("Unknown record or too many cases in the input file");
                abort_run();
            end
        end
        $fclose(fd);
    endtask

    // ==================================================
    // Stimulus, all driven on the falling edge
    // ==================================================
    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            if (cycles == reset_timeout) begin
                $display("Reset was not released within %0d cycles", reset_timeout);
                abort_run();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic prepare_row(input scroll_reg_u s, input logic [7:0] row);
        int cycles;
        scroll   = s;
        next_row = row;
        prep     = 1'b1;
        @(negedge clk);
        prep   = 1'b0;
        cycles = 0;
        while (done !== 1'b1) begin
            if (cycles == prep_timeout) begin
                $display("No done pulse within %0d cycles of prep", prep_timeout);
                abort_run();
            end
            @(negedge clk);
            cycles++;
        end
        @(negedge clk);
        check_done(1'b0, "cycle after the done pulse");
    endtask

    // Mixer read, data is back one clock later
    task automatic read_pixel(input logic en, input logic [`PIXEL_ADDR_W-1:0] addr,
                              input pixel_out_u expected, input int idx);
        enable     = en;
        pixel_addr = addr;
        @(negedge clk);
        check_pixel(pixel_data, expected, idx);
        check_done(1'b0, "during pixel reads");
    endtask

    initial begin
        logic prepared;
        scroll.raw        = '0;
        next_row          = '0;
        enable            = 1'b0;
        prep              = 1'b0;
        pixel_addr        = '0;
        tilram_rddata.raw = '0;
        patram_rddata.raw = '0;
        num_cases         = 0;
        prepared          = 1'b0;
        load_input_file();
        wait_reset_release();
        repeat (8) begin
            @(negedge clk);
            check_done(1'b0, "before the first prep");
        end
        for (int i = 0; i < num_cases; i++) begin
            // New scroll or row needs a fresh prepare
            if (!prepared || scroll.raw != case_scroll[i].raw || next_row != case_row[i]) begin
                prepare_row(case_scroll[i], case_row[i]);
                prepared = 1'b1;
            end
            read_pixel(case_enable[i], case_addr[i], case_expect[i], i);
        end
        if (num_cases > 0 && uut.u_props.assert_errors == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("No cases were run or an assertion failed");
            abort_run();
        end
    end

endmodule : tb_tile_engine

`default_nettype wire

/* verification/tile_engine_input.txt */
# T addr word = Tile RAM word, P addr word = Pattern RAM word, all hex
# C scroll next_row enable pixel_addr expected_pixel, all hex
T 400 0053004E00490044
T 40F 0054005900000000
T 000 007C007C007C007C
T 00F 007C007C007C007C
P 004 8765432176543210
P 005 A987654398765432
P 006 CBA98765BA987654
P 007 EDCBA987DCBA9876
C 00000000 03 1 000 13
C 00000000 03 1 005 18
C 00000000 03 1 009 29
C 00000000 03 1 012 36
C 00000000 03 1 01F 44
C 00000000 03 1 020 00
C 01FE01F3 08 1 000 6A
C 01FE01F3 08 1 004 66
C 01FE01F3 08 1 005 56
C 01FE01F3 08 1 00C 5D
C 01FE01F3 08 1 00D 16
C 01FE01F3 08 1 018 2A
C 01FE01F3 08 1 01D 31
C 01FE01F3 08 1 02C 41
C 01FE01F3 08 0 000 00
C 01FE01F3 08 0 00D 00
C 01FE01F3 08 1 000 6A
C 01FE01F3 08 1 00D 16
C 00000005 01 1 000 16
C 00000005 01 1 003 28
C 00000005 01 1 00E 39

/* list.f */
+incdir+hdl
hdl/tile_mem_pkg.sv
hdl/tile_geom_pkg.sv
hdl/row_geometry_if.sv
hdl/tilram_fetcher.sv
hdl/patram_fetcher.sv
hdl/pixel_row_buffer.sv
hdl/tile_engine.sv
verification/tb_clock_gen.sv
verification/tile_engine_properties.sv
verification/tb_tile_engine.sv

/* run.sh */
#!/bin/sh
# Build and run the tile engine testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_tile_engine -f list.f -o tb_tile_engine_sim

# Keep the log of a failing run for the search below
obj_dir/tb_tile_engine_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
